// File: source/obj_pkg.sv
package obj_pkg;

    // table geometry
    localparam int NUM_OBJ    = 128;                  // sprite entries
    localparam int OBJ_WORDS  = 4;                    // 16-bit words per entry
    localparam int TBL_WORDS  = NUM_OBJ * OBJ_WORDS;  // whole external table
    localparam int BANK_WORDS = TBL_WORDS / 2;        // even and odd banks split it

    // entry fields
    localparam int W0_ACTIVE  = 15;   // word 0, sprite enabled
    localparam int W0_HSZ_LO  = 10;   // word 0, height code at 11:10
    localparam int W3_HFLIP   = 8;    // word 3
    localparam int W3_VFLIP   = 9;
    localparam int MIN_HEIGHT = 16;   // height code 0

    typedef logic [ 6:0] obj_idx_t;     // entry number
    typedef logic [ 8:0] tbl_addr_t;    // word address in external RAM
    typedef logic [ 7:0] bank_addr_t;   // {entry, word bit 1}
    typedef logic [15:0] obj_word_t;    // one table word
    typedef logic [15:0] obj_code_t;    // tile code
    typedef logic [ 8:0] obj_pos_t;     // screen coordinate, also line counts
    typedef logic [ 6:0] obj_attr_t;    // palette and priority

    // one record per sprite hit, goes to the line drawer
    typedef struct packed {
        obj_code_t code;      // base code + row / 16
        obj_attr_t attr;
        logic      hflip;     // already merged with global flip
        logic      vflip;
        obj_pos_t  hpos;      // start column
        logic [3:0] ysub;     // row inside the 16-line tile
    } obj_draw_t;

endpackage

// File: source/mmr_pkg.sv
package mmr_pkg;

    typedef logic [1:0] cpu_addr_t;   // register select
    typedef logic [9:0] off_t;        // scroll style offsets

    // register map
    localparam cpu_addr_t REG_XOFF = 2'd0;
    localparam cpu_addr_t REG_YOFF = 2'd1;
    localparam cpu_addr_t REG_CFG  = 2'd2;
    localparam cpu_addr_t REG_TRIG = 2'd3;   // write only, starts a DMA

    typedef struct packed {
        logic        we;
        cpu_addr_t   addr;
        logic [15:0] dout;    // data from the CPU
        logic [ 1:0] dsn;     // byte strobes, active low, bit 0 is low byte
    } cpu_bus_t;

    // configuration byte
    typedef struct packed {
        logic [2:0] rsvd_hi;  // stored, no function here
        logic       dma_en;
        logic [1:0] rsvd_lo;
        logic       gvf;      // global vertical flip
        logic       ghf;      // global horizontal flip
    } mmr_cfg_t;

endpackage

// File: source/obj_mmr.sv
`timescale 1ns/1ns

module obj_mmr (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cs,
    input  mmr_pkg::cpu_bus_t  cpu,
    output mmr_pkg::off_t      xoffset,
    output mmr_pkg::off_t      yoffset,
    output mmr_pkg::mmr_cfg_t  cfg,
    output logic               dma_trig     // one cycle, after the write
);

    logic wr;   // valid write this cycle

    // merges the enabled byte lanes into the old value
    function automatic logic [15:0] lane_wr(
        input logic [15:0] old,
        input logic [15:0] din,
        input logic [ 1:0] dsn
    );
        logic [15:0] res;
        res = old;
        if (!dsn[0]) res[ 7:0] = din[ 7:0];   // low byte
        if (!dsn[1]) res[15:8] = din[15:8];   // high byte
        return res;
    endfunction

    assign wr = cs && cpu.we;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            xoffset  <= '0;
            yoffset  <= '0;
            cfg      <= '0;   // dma off, no flips
            dma_trig <= 1'b0;
        end else begin
            // trigger stores nothing, only the pulse
            dma_trig <= wr && cpu.addr == mmr_pkg::REG_TRIG;
            if (wr) begin
                case (cpu.addr)
                    mmr_pkg::REG_XOFF: begin
                        xoffset <= mmr_pkg::off_t'(lane_wr({6'd0, xoffset}, cpu.dout, cpu.dsn));
                    end
                    mmr_pkg::REG_YOFF: begin
                        yoffset <= mmr_pkg::off_t'(lane_wr({6'd0, yoffset}, cpu.dout, cpu.dsn));
                    end
                    mmr_pkg::REG_CFG: begin
                        if (!cpu.dsn[0]) cfg <= cpu.dout[7:0];  // byte wide register
                    end
                    default: ;   // REG_TRIG handled above
                endcase
            end
        end
    end

endmodule

// File: source/obj_dma.sv
`timescale 1ns/1ns

module obj_dma (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 dma_en,
    input  logic                 dma_trig,
    input  logic                 vs,
    // external table RAM
    output obj_pkg::tbl_addr_t   dma_addr,
    input  obj_pkg::obj_word_t   dma_data,
    output logic                 dma_bsy,
    // internal banks
    output obj_pkg::bank_addr_t  wr_addr,
    output obj_pkg::obj_word_t   wr_data,
    output logic                 we_even,
    output logic                 we_odd
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_VS,    // trigger accepted, pending until vs
        ST_COPY
    } state_t;

    state_t              state;
    logic                vs_l;
    logic                vs_rise;
    logic                fetch;     // address phase running
    logic                wr_vld;    // external data arrives this cycle
    obj_pkg::tbl_addr_t  wr_word;   // dma_addr one cycle late, matches RAM latency
    logic                last_addr;

    assign vs_rise   = vs && !vs_l;
    assign last_addr = dma_addr == obj_pkg::tbl_addr_t'(obj_pkg::TBL_WORDS - 1);
    assign dma_bsy   = state == ST_COPY;    // 513 cycles per copy

    // entry * 2 + word bit 1, bit 0 picks the bank
    assign wr_addr = {wr_word[8:2], wr_word[1]};
    assign wr_data = dma_data;                  // written the cycle it arrives
    assign we_even = wr_vld && !wr_word[0];     // words 0 and 2
    assign we_odd  = wr_vld &&  wr_word[0];     // words 1 and 3

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            vs_l     <= 1'b0;
            fetch    <= 1'b0;
            wr_vld   <= 1'b0;
            dma_addr <= '0;
        end else begin
            vs_l   <= vs;
            wr_vld <= fetch;
            case (state)
                ST_IDLE: begin
                    if (dma_trig && dma_en) state <= ST_WAIT_VS;   // en sampled with pulse
                end
                ST_WAIT_VS: begin
                    if (vs_rise) begin
                        state    <= ST_COPY;
                        fetch    <= 1'b1;
                        dma_addr <= '0;
                    end
                end
                ST_COPY: begin
                    if (fetch) begin
                        if (last_addr) fetch <= 1'b0;      // 511 was the last read
                        else dma_addr <= dma_addr + 1'b1;
                    end else begin
                        state    <= ST_IDLE;               // last word written now
                        dma_addr <= '0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        wr_word <= dma_addr;
    end

endmodule

// File: source/obj_table_ram.sv
`timescale 1ns/1ns

module obj_table_ram (
    input  logic                 clk,
    // DMA side
    input  obj_pkg::bank_addr_t  wr_addr,
    input  obj_pkg::obj_word_t   wr_data,
    input  logic                 we,
    // scanner side
    input  obj_pkg::bank_addr_t  rd_addr,
    output obj_pkg::obj_word_t   rd_data
);

    // one bank, half of the table
    obj_pkg::obj_word_t mem [obj_pkg::BANK_WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];   // one cycle read, old data on collision
    end

endmodule

// File: source/obj_scan.sv
`timescale 1ns/1ns

module obj_scan (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 hs,
    input  obj_pkg::obj_pos_t    vdump,
    input  mmr_pkg::off_t        xoffset,
    input  mmr_pkg::off_t        yoffset,
    input  logic                 ghf,
    input  logic                 gvf,
    // table banks
    output obj_pkg::bank_addr_t  rd_addr,
    input  obj_pkg::obj_word_t   rd_even,
    input  obj_pkg::obj_word_t   rd_odd,
    // line drawer
    output obj_pkg::obj_draw_t   draw,
    output logic                 dr_start,
    input  logic                 dr_busy
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_A,     // address words 0/1
        ST_READ_B,     // address words 2/3, 0/1 come back
        ST_DECIDE,     // 2/3 come back, hit test
        ST_WAIT_BUSY   // drawer handshake
    } state_t;

    state_t              state;
    obj_pkg::obj_idx_t   idx;        // current entry
    obj_pkg::obj_pos_t   line;       // vdump latched at hs
    obj_pkg::obj_word_t  w0;         // held over the second read
    obj_pkg::obj_word_t  w1;
    logic                hs_l;
    logic                hs_rise;
    logic                last;
    logic                step;       // entry done, move on

    // decode of the current entry
    logic                active;
    logic [1:0]          hcode;
    obj_pkg::obj_pos_t   height;
    obj_pkg::obj_pos_t   row;
    obj_pkg::obj_pos_t   erow;       // row after vertical flip
    obj_pkg::obj_pos_t   hraw;
    logic                vf;
    logic                hit;
    obj_pkg::obj_draw_t  nxt;

    assign hs_rise = hs && !hs_l;
    assign last    = idx == obj_pkg::obj_idx_t'(obj_pkg::NUM_OBJ - 1);
    assign rd_addr = {idx, state == ST_READ_B};   // same address for both banks

    // no hit, or the drawer took it and went idle again
    assign step = (state == ST_DECIDE && !hit) ||
                  (state == ST_WAIT_BUSY && !dr_start && !dr_busy);

    always_comb begin
        active = w0[obj_pkg::W0_ACTIVE];
        hcode  = w0[obj_pkg::W0_HSZ_LO +: 2];
        height = obj_pkg::obj_pos_t'(obj_pkg::MIN_HEIGHT) << hcode;   // 16..128
        row    = line + yoffset[8:0] - w0[8:0];                       // wraps at 512
        hit    = active && row < height;
        vf     = rd_odd[obj_pkg::W3_VFLIP] ^ gvf;
        erow   = vf ? height - 9'd1 - row : row;
        hraw   = rd_even[8:0] - xoffset[8:0];                         // x in word 2

        nxt.code  = w1 + obj_pkg::obj_code_t'(erow[8:4]);  // one tile per 16 lines
        nxt.attr  = rd_odd[6:0];
        nxt.hflip = rd_odd[obj_pkg::W3_HFLIP] ^ ghf;
        nxt.vflip = vf;
        nxt.hpos  = ghf ? 9'h1ff - hraw : hraw;           // mirrored screen
        nxt.ysub  = erow[3:0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            idx      <= '0;
            hs_l     <= 1'b0;
            dr_start <= 1'b0;
            draw     <= '0;
        end else begin
            hs_l     <= hs;
            dr_start <= 1'b0;   // pulse
            if (hs_rise) begin
                idx   <= '0;          // old walk dropped
                state <= ST_READ_A;
            end else if (step) begin
                idx   <= idx + 1'b1;
                state <= last ? ST_IDLE : ST_READ_A;
            end else begin
                case (state)
                    ST_READ_A: state <= ST_READ_B;
                    ST_READ_B: state <= ST_DECIDE;
                    ST_DECIDE: begin
                        draw     <= nxt;      // only hits reach here
                        dr_start <= 1'b1;
                        state    <= ST_WAIT_BUSY;
                    end
                    ST_WAIT_BUSY: ;           // drawer still busy
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hs_rise) line <= vdump;
        if (state == ST_READ_B) begin
            w0 <= rd_even;    // y, height, active
            w1 <= rd_odd;     // base code
        end
    end

endmodule

// File: source/obj_ctrl.sv
`timescale 1ns/1ns

module obj_ctrl (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                cs,
    input  mmr_pkg::cpu_bus_t   cpu,
    // external sprite RAM
    output obj_pkg::tbl_addr_t  dma_addr,
    input  obj_pkg::obj_word_t  dma_data,
    output logic                dma_bsy,
    // video timing
    input  logic                vs,
    input  logic                hs,
    input  obj_pkg::obj_pos_t   vdump,
    // line drawer
    output obj_pkg::obj_draw_t  draw,
    output logic                dr_start,
    input  logic                dr_busy
);

    mmr_pkg::off_t        xoffset;
    mmr_pkg::off_t        yoffset;
    mmr_pkg::mmr_cfg_t    cfg;
    logic                 dma_trig;
    obj_pkg::bank_addr_t  wr_addr;
    obj_pkg::obj_word_t   wr_data;
    logic                 we_even;
    logic                 we_odd;
    obj_pkg::bank_addr_t  rd_addr;
    obj_pkg::obj_word_t   rd_even;
    obj_pkg::obj_word_t   rd_odd;

    obj_mmr u_mmr (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .cs       ( cs       ),
        .cpu      ( cpu      ),
        .xoffset  ( xoffset  ),
        .yoffset  ( yoffset  ),
        .cfg      ( cfg      ),
        .dma_trig ( dma_trig )
    );

    obj_dma u_dma (
        .clk      ( clk        ),
        .arst_n   ( arst_n     ),
        .dma_en   ( cfg.dma_en ),
        .dma_trig ( dma_trig   ),
        .vs       ( vs         ),
        .dma_addr ( dma_addr   ),
        .dma_data ( dma_data   ),
        .dma_bsy  ( dma_bsy    ),
        .wr_addr  ( wr_addr    ),
        .wr_data  ( wr_data    ),
        .we_even  ( we_even    ),
        .we_odd   ( we_odd     )
    );

    // words 0 and 2
    obj_table_ram u_even (
        .clk     ( clk     ),
        .wr_addr ( wr_addr ),
        .wr_data ( wr_data ),
        .we      ( we_even ),
        .rd_addr ( rd_addr ),
        .rd_data ( rd_even )
    );

    // words 1 and 3
    obj_table_ram u_odd (
        .clk     ( clk     ),
        .wr_addr ( wr_addr ),
        .wr_data ( wr_data ),
        .we      ( we_odd  ),
        .rd_addr ( rd_addr ),
        .rd_data ( rd_odd  )
    );

    obj_scan u_scan (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .hs       ( hs       ),
        .vdump    ( vdump    ),
        .xoffset  ( xoffset  ),
        .yoffset  ( yoffset  ),
        .ghf      ( cfg.ghf  ),
        .gvf      ( cfg.gvf  ),
        .rd_addr  ( rd_addr  ),
        .rd_even  ( rd_even  ),
        .rd_odd   ( rd_odd   ),
        .draw     ( draw     ),
        .dr_start ( dr_start ),
        .dr_busy  ( dr_busy  )
    );

endmodule

// File: test/obj_ctrl_tb.sv
`timescale 1ns/1ns

module obj_ctrl_tb;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_ROWS   = 12;

    typedef struct {
        string      name;
        int         yoff;
        int         xoff;
        logic [7:0] cfg;       // ghf bit 0, gvf bit 1, dma_en bit 4
        int         line;      // vdump given with hs
        int         busy;      // drawer busy cycles per record
        bit         dma;       // trigger plus vs pulse
        bit         rewrite;   // fresh random table in external RAM first
    } test_row_t;

    logic                clk;
    logic                arst_n;
    logic                cs;
    mmr_pkg::cpu_bus_t   cpu;
    obj_pkg::tbl_addr_t  dma_addr;
    obj_pkg::obj_word_t  dma_data;
    logic                dma_bsy;
    logic                vs;
    logic                hs;
    obj_pkg::obj_pos_t   vdump;
    obj_pkg::obj_draw_t  draw;
    logic                dr_start;
    logic                dr_busy;

    obj_pkg::obj_word_t  ext_ram [512];   // external sprite RAM
    obj_pkg::obj_word_t  ref_tbl [512];   // table the banks hold after the last copy
    obj_pkg::tbl_addr_t  ram_addr_q;
    obj_pkg::obj_draw_t  got_q [$];       // records seen on dr_start
    obj_pkg::obj_draw_t  exp_q [$];
    test_row_t           rows [NUM_ROWS];
    string               cur_name;        // row now on the line
    int                  busy_len;
    int                  errors;
    int                  checks;

    obj_ctrl i_obj_ctrl (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // external RAM answers one cycle after the address
    always @(negedge clk) ram_addr_q = dma_addr;
    always @(posedge clk) begin
        #10 dma_data = ext_ram[ram_addr_q];
    end

    // drawer model goes busy the cycle after dr_start
    always begin
        @(negedge clk);
        if (dr_start && busy_len > 0) begin
            @(posedge clk);
            #10 dr_busy = 1'b1;
            repeat (busy_len) @(posedge clk);
            #10 dr_busy = 1'b0;
        end
    end

    // a record handed over while the drawer is busy would be lost
    always @(negedge clk) begin
        if (dr_start) begin
            got_q.push_back(draw);   // one record per pulse
            compare({cur_name, " dr_busy at dr_start"}, 64'(1'b0), 64'(dr_busy));
        end
    end

    initial begin
        #(NUM_ROWS * 2000 * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic compare_draw(input string name, input obj_pkg::obj_draw_t e,
                                input obj_pkg::obj_draw_t g);
        compare({name, " code"}, 64'(e.code), 64'(g.code));
        compare({name, " ysub"}, 64'(e.ysub), 64'(g.ysub));
        compare({name, " attr"}, 64'(e.attr), 64'(g.attr));
        compare({name, " hpos"}, 64'(e.hpos), 64'(g.hpos));
        compare({name, " hflip"}, 64'(e.hflip), 64'(g.hflip));
        compare({name, " vflip"}, 64'(e.vflip), 64'(g.vflip));
    endtask

    task automatic cpu_write(input mmr_pkg::cpu_addr_t addr, input logic [15:0] data);
        @(posedge clk);
        #10;
        cs       = 1'b1;
        cpu.we   = 1'b1;
        cpu.addr = addr;
        cpu.dout = data;
        cpu.dsn  = 2'b00;   // both lanes
        @(posedge clk);
        #10;
        cs     = 1'b0;
        cpu.we = 1'b0;
    endtask

    // forces an active sprite with a given height code and y
    task automatic plant_entry(input int idx, input int hc, input int y);
        ext_ram[4 * idx] = {1'b1, 3'b000, 2'(hc), 1'b0, 9'(y)};
    endtask

    task automatic fill_ext_ram();
        for (int i = 0; i < 512; i++) ext_ram[i] = obj_pkg::obj_word_t'($urandom);
        for (int i = 0; i < 128; i++) ext_ram[4 * i][15] = ($urandom % 4) == 0;  // quarter on
        plant_entry(3, 0, 505);     // these wrap past line 511
        plant_entry(40, 1, 490);
        plant_entry(77, 2, 470);
        plant_entry(120, 3, 420);
    endtask

    // hit rule applied to the known table copy in index order
    task automatic build_expected(input test_row_t r);
        int height;
        int row;
        int erow;
        int hraw;
        logic vf;
        obj_pkg::obj_draw_t d;
        exp_q.delete();
        for (int i = 0; i < 128; i++) begin
            height = 16 << int'(ref_tbl[4 * i][11:10]);
            row    = (r.line + r.yoff - int'(ref_tbl[4 * i][8:0])) & 511;
            if (ref_tbl[4 * i][15] && row < height) begin
                vf      = ref_tbl[4 * i + 3][9] ^ r.cfg[1];
                erow    = vf ? height - 1 - row : row;
                hraw    = (int'(ref_tbl[4 * i + 2][8:0]) - r.xoff) & 511;
                d.code  = ref_tbl[4 * i + 1] + 16'(erow / 16);
                d.attr  = ref_tbl[4 * i + 3][6:0];
                d.hflip = ref_tbl[4 * i + 3][8] ^ r.cfg[0];
                d.vflip = vf;
                d.hpos  = 9'(r.cfg[0] ? 511 - hraw : hraw);
                d.ysub  = 4'(erow % 16);
                exp_q.push_back(d);
            end
        end
    endtask

    task automatic run_dma(input test_row_t r);
        int n;
        cpu_write(mmr_pkg::REG_TRIG, 16'h0000);
        @(posedge clk);
        #10 vs = 1'b1;
        @(posedge clk);
        #10 vs = 1'b0;
        @(negedge clk);
        if (!r.cfg[4]) begin
            repeat (20) begin   // trigger must be dropped
                compare({r.name, " dma_bsy idle"}, 64'(1'b0), 64'(dma_bsy));
                @(negedge clk);
            end
        end else begin
            n = 0;
            while (!dma_bsy && n < 20) begin
                n++;
                @(negedge clk);
            end
            if (!dma_bsy) begin
                errors++;
                $display("%s: dma_bsy never went high after vs", r.name);
            end else begin
                n = 0;
                while (dma_bsy && n < 600) begin
                    if (n < 512) compare({r.name, " dma_addr"}, 64'(n), 64'(dma_addr));
                    n++;
                    @(negedge clk);
                end
                compare({r.name, " dma_bsy cycles"}, 64'(513), 64'(n));
                ref_tbl = ext_ram;   // banks now mirror the external table
            end
        end
    endtask

    task automatic run_line(input test_row_t r);
        int wait_cyc;
        build_expected(r);
        got_q.delete();
        cur_name = r.name;
        busy_len = r.busy;
        wait_cyc = 3 * 128 + exp_q.size() * (r.busy + 4) + 40;   // walk plus handshakes
        if (wait_cyc < 900) wait_cyc = 900;
        @(posedge clk);
        #10;
        vdump = 9'(r.line);
        hs    = 1'b1;
        @(posedge clk);
        #10 hs = 1'b0;
        repeat (wait_cyc) @(posedge clk);
        compare({r.name, " draw count"}, 64'(exp_q.size()), 64'(got_q.size()));
        for (int k = 0; k < exp_q.size() && k < got_q.size(); k++) begin
            compare_draw($sformatf("%s #%0d", r.name, k), exp_q[k], got_q[k]);
        end
    endtask

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        cs       = 1'b0;
        cpu      = '0;
        dma_data = '0;
        vs       = 1'b0;
        hs       = 1'b0;
        vdump    = '0;
        dr_busy  = 1'b0;
        busy_len = 0;
        errors   = 0;
        checks   = 0;
        cur_name = "reset";
        void'($urandom(32'hcb37));
        foreach (ext_ram[i]) ext_ram[i] = obj_pkg::obj_word_t'(i);   // active bits stay clear
        foreach (ref_tbl[i]) ref_tbl[i] = '0;   // nothing copied yet so no sprite is active
        rows[0]  = '{"reset_idle",      0,   0, 8'h00, 100,  0, 1'b0, 1'b0};
        rows[1]  = '{"dma_load",        0,   0, 8'h10,  40,  0, 1'b1, 1'b1};
        rows[2]  = '{"line_wrap",       0,   0, 8'h10,   5,  0, 1'b0, 1'b0};
        rows[3]  = '{"all_heights",     0,   0, 8'h10, 508,  2, 1'b0, 1'b0};
        rows[4]  = '{"offsets",        37, 123, 8'h10, 470,  1, 1'b0, 1'b0};
        rows[5]  = '{"ghf",             0, 200, 8'h11,   5,  0, 1'b0, 1'b0};
        rows[6]  = '{"gvf",           300,   0, 8'h12, 220,  0, 1'b0, 1'b0};
        rows[7]  = '{"ghf_gvf",       600, 700, 8'h13, 430,  3, 1'b0, 1'b0};
        rows[8]  = '{"back_pressure",   0,   0, 8'h10,   5, 40, 1'b0, 1'b0};
        rows[9]  = '{"dma_disabled",    0,   0, 8'h00,   5,  0, 1'b1, 1'b1};
        rows[10] = '{"dma_reenabled",   0,   0, 8'h10,   5,  0, 1'b1, 1'b0};
        rows[11] = '{"new_table_flip", 11,   9, 8'h13,  10,  3, 1'b0, 1'b0};
        repeat (2) @(posedge clk);
        #10 arst_n = 1'b1;
        @(negedge clk);
        compare("reset dr_start", 64'(1'b0), 64'(dr_start));
        compare("reset dma_bsy", 64'(1'b0), 64'(dma_bsy));
        compare("reset dma_addr", 64'(0), 64'(dma_addr));
        compare("reset draw", 64'(0), 64'(draw));
        foreach (rows[r]) begin
            if (rows[r].rewrite) fill_ext_ram();
            cpu_write(mmr_pkg::REG_YOFF, 16'(rows[r].yoff));
            cpu_write(mmr_pkg::REG_XOFF, 16'(rows[r].xoff));
            cpu_write(mmr_pkg::REG_CFG, {8'h00, rows[r].cfg});
            if (rows[r].dma) run_dma(rows[r]);
            run_line(rows[r]);
        end
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
source/obj_pkg.sv
source/mmr_pkg.sv
source/obj_mmr.sv
source/obj_dma.sv
source/obj_table_ram.sv
source/obj_scan.sv
source/obj_ctrl.sv
test/obj_ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the sprite controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module obj_ctrl_tb \
    -f all.f --Mdir obj_dir -o obj_ctrl_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/obj_ctrl_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
